// File: include/lz4_macros.svh
`ifndef LZ4_MACROS_SVH
`define LZ4_MACROS_SVH

// sequence descriptor widths
`define LZ4_LEN_W 16
`define LZ4_OFS_W 16

// literal buffer size in bytes, power of two
`define LZ4_FIFO_DEPTH 512

// token nibble that says an extension follows
`define LZ4_LIT_NIB_MAX 15

// shortest match the format can express
`define LZ4_MIN_MATCH 4

// value of every extension byte but the final one
`define LZ4_EXT_BYTE 255

`endif

// File: design/lz4_pkg.sv
`include "lz4_macros.svh"

package lz4_pkg;

	// emitter walks these in order, skipping what a sequence lacks
	typedef enum logic [3:0]
	{
		ST_IDLE,
		ST_TOKEN,
		ST_LIT_EXT,
		ST_LITERAL,
		ST_OFS_LO,
		ST_OFS_HI,
		ST_MAT_EXT,
		ST_SEQ_DONE
	} emit_state_t;

	// literal or match length
	typedef logic [`LZ4_LEN_W-1:0] len_t;

	// back reference distance
	typedef logic [`LZ4_OFS_W-1:0] ofs_t;

	// one half of the token byte
	typedef logic [3:0] nibble_t;

endpackage

// File: design/lz4_length_coder.sv
`timescale 1ns/1ps
`include "lz4_macros.svh"

module lz4_length_coder (
	input  logic             clk,
	input  logic             rstN,
	input  logic             seq_valid,
	input  lz4_pkg::len_t    lit_len,
	input  lz4_pkg::len_t    match_len,
	input  lz4_pkg::ofs_t    match_offset,
	input  logic             last,
	output logic             desc_valid,
	output lz4_pkg::nibble_t lit_nib,
	output lz4_pkg::nibble_t mat_nib,
	output lz4_pkg::len_t    lit_ext_cnt,
	output logic [7:0]       lit_ext_last,
	output lz4_pkg::len_t    mat_ext_cnt,
	output logic [7:0]       mat_ext_last,
	output lz4_pkg::len_t    lit_cnt,
	output lz4_pkg::ofs_t    ofs,
	output logic             is_last
);
	import lz4_pkg::*;

	localparam int LIT_BIAS = `LZ4_LIT_NIB_MAX;
	localparam int MAT_BIAS = `LZ4_LIT_NIB_MAX + `LZ4_MIN_MATCH;

	len_t       lit_corr;
	len_t       mat_corr;
	len_t       mat_tok;
	len_t       lit_ext_cnt_c;
	len_t       mat_ext_cnt_c;
	logic [7:0] lit_ext_last_c;
	logic [7:0] mat_ext_last_c;
	nibble_t    lit_nib_c;
	nibble_t    mat_nib_c;

	// n = corr/255 taken as (corr + corr/256)/256, then fixed up
	// by one when the remainder lands on 255
	function automatic void split_ext(
		input  len_t       corr,
		output len_t       n,
		output logic [7:0] rem
	);
		logic [`LZ4_LEN_W:0] conv;
		logic [`LZ4_LEN_W:0] n_raw;
		logic [`LZ4_LEN_W:0] remain;
		conv   = {1'b0, corr} + (corr >> 8);
		n_raw  = conv >> 8;
		remain = {1'b0, corr} - (n_raw << 8) + n_raw;
		if (remain == `LZ4_EXT_BYTE)
		begin
			n   = len_t'(n_raw + 1'b1);
			rem = 8'h00;
		end
		else
		begin
			n   = len_t'(n_raw);
			rem = remain[7:0];
		end
	endfunction

	always_comb
	begin
		lit_corr = lit_len - len_t'(LIT_BIAS);
		mat_corr = match_len - len_t'(MAT_BIAS);
		mat_tok  = match_len - len_t'(`LZ4_MIN_MATCH);
		split_ext(lit_corr, lit_ext_cnt_c, lit_ext_last_c);
		split_ext(mat_corr, mat_ext_cnt_c, mat_ext_last_c);
		lit_nib_c = (lit_len >= len_t'(LIT_BIAS)) ? nibble_t'(`LZ4_LIT_NIB_MAX) : lit_len[3:0];
		// last sequence carries no match at all
		if (last)
			mat_nib_c = '0;
		else if (match_len >= len_t'(MAT_BIAS))
			mat_nib_c = nibble_t'(`LZ4_LIT_NIB_MAX);
		else
			mat_nib_c = mat_tok[3:0];
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			desc_valid <= 1'b0;
		else
			desc_valid <= seq_valid;
	end

	// descriptor held until the next sequence
	always_ff @(posedge clk)
	begin
		if (seq_valid)
		begin
			lit_nib      <= lit_nib_c;
			mat_nib      <= mat_nib_c;
			lit_ext_cnt  <= lit_ext_cnt_c;
			lit_ext_last <= lit_ext_last_c;
			mat_ext_cnt  <= mat_ext_cnt_c;
			mat_ext_last <= mat_ext_last_c;
			lit_cnt      <= lit_len;
			ofs          <= match_offset;
			is_last      <= last;
		end
	end

	a_min_match: assert property (@(posedge clk) disable iff (!rstN)
		seq_valid && !last |-> match_len >= len_t'(`LZ4_MIN_MATCH))
		else $error("match_len %0d below minimum on a non-last sequence", match_len);

endmodule

// File: design/lz4_literal_fifo.sv
`timescale 1ns/1ps
`include "lz4_macros.svh"

module lz4_literal_fifo #(
	parameter int DEPTH = `LZ4_FIFO_DEPTH
) (
	input  logic       clk,
	input  logic       rstN,
	input  logic       wr_en,
	input  logic [7:0] wr_data,
	input  logic       rd_en,
	output logic [7:0] rd_data,
	output logic       empty,
	output logic       full
);

	localparam int AW = $clog2(DEPTH);

	logic [7:0]    mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

	// head byte is always on the output
	assign rd_data = mem[rd_ptr];

	////////////////////////////////////////////////////////////
	// pointers and fill level
	////////////////////////////////////////////////////////////

	// pointers wrap on their own since DEPTH is a power of two
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign empty = (count == '0);
	assign full  = (count == (AW+1)'(DEPTH));

	a_no_overflow: assert property (@(posedge clk) disable iff (!rstN)
		wr_en |-> !full)
		else $error("literal write while FIFO full");

	a_no_underflow: assert property (@(posedge clk) disable iff (!rstN)
		rd_en |-> !empty)
		else $error("literal read while FIFO empty");

endmodule

// File: design/lz4_sequence_emitter.sv
`timescale 1ns/1ps
`include "lz4_macros.svh"

module lz4_sequence_emitter (
	input  logic             clk,
	input  logic             rstN,
	input  logic             desc_valid,
	input  lz4_pkg::nibble_t lit_nib,
	input  lz4_pkg::nibble_t mat_nib,
	input  lz4_pkg::len_t    lit_ext_cnt,
	input  logic [7:0]       lit_ext_last,
	input  lz4_pkg::len_t    mat_ext_cnt,
	input  logic [7:0]       mat_ext_last,
	input  lz4_pkg::len_t    lit_cnt,
	input  lz4_pkg::ofs_t    ofs,
	input  logic             is_last,
	input  logic [7:0]       rd_data,
	input  logic             empty,
	output logic             rd_en,
	output logic             out_valid,
	output logic [7:0]       out_byte,
	output logic             seq_done,
	output logic             busy
);
	import lz4_pkg::*;

	emit_state_t state;
	emit_state_t state_nxt;
	emit_state_t after_lits;
	len_t        cnt;
	len_t        cnt_nxt;
	logic        lit_ext_on;
	logic        mat_ext_on;

	assign lit_ext_on = (lit_nib == nibble_t'(`LZ4_LIT_NIB_MAX));
	assign mat_ext_on = (mat_nib == nibble_t'(`LZ4_LIT_NIB_MAX));

	// last sequence stops after its literals
	assign after_lits = is_last ? ST_SEQ_DONE : ST_OFS_LO;

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= ST_IDLE;
			cnt   <= '0;
		end
		else
		begin
			state <= state_nxt;
			cnt   <= cnt_nxt;
		end
	end

	// cnt counts down the bytes left in the current field, zero on the final one
	always_comb
	begin
		state_nxt = state;
		cnt_nxt   = cnt;
		case (state)
			ST_IDLE:
			begin
				if (desc_valid)
					state_nxt = ST_TOKEN;
			end
			ST_TOKEN:
			begin
				if (lit_ext_on)
				begin
					state_nxt = ST_LIT_EXT;
					cnt_nxt   = lit_ext_cnt;
				end
				else if (lit_cnt != '0)
				begin
					state_nxt = ST_LITERAL;
					cnt_nxt   = lit_cnt - 1'b1;
				end
				else
					state_nxt = after_lits;
			end
			ST_LIT_EXT:
			begin
				// an extension implies at least 15 literals
				if (cnt == '0)
				begin
					state_nxt = ST_LITERAL;
					cnt_nxt   = lit_cnt - 1'b1;
				end
				else
					cnt_nxt = cnt - 1'b1;
			end
			ST_LITERAL:
			begin
				if (cnt == '0)
					state_nxt = after_lits;
				else
					cnt_nxt = cnt - 1'b1;
			end
			ST_OFS_LO:
				state_nxt = ST_OFS_HI;
			ST_OFS_HI:
			begin
				if (mat_ext_on)
				begin
					state_nxt = ST_MAT_EXT;
					cnt_nxt   = mat_ext_cnt;
				end
				else
					state_nxt = ST_SEQ_DONE;
			end
			ST_MAT_EXT:
			begin
				if (cnt == '0)
					state_nxt = ST_SEQ_DONE;
				else
					cnt_nxt = cnt - 1'b1;
			end
			ST_SEQ_DONE:
				state_nxt = ST_IDLE;
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////
	// byte output
	////////////////////////////////////////////////////////////

	always_comb
	begin
		out_valid = 1'b1;
		out_byte  = 8'h00;
		case (state)
			ST_TOKEN:   out_byte = {lit_nib, mat_nib};
			ST_LIT_EXT: out_byte = (cnt == '0) ? lit_ext_last : 8'(`LZ4_EXT_BYTE);
			ST_LITERAL: out_byte = rd_data;
			// offset goes out little endian
			ST_OFS_LO:  out_byte = ofs[7:0];
			ST_OFS_HI:  out_byte = ofs[15:8];
			ST_MAT_EXT: out_byte = (cnt == '0) ? mat_ext_last : 8'(`LZ4_EXT_BYTE);
			default:    out_valid = 1'b0;
		endcase
	end

	assign rd_en    = (state == ST_LITERAL);
	assign seq_done = (state == ST_SEQ_DONE);
	assign busy     = desc_valid || (state != ST_IDLE);

	a_desc_in_idle: assert property (@(posedge clk) disable iff (!rstN)
		desc_valid |-> state == ST_IDLE)
		else $error("new descriptor while emitter in state %s", state.name());

	// literals must already sit in the FIFO when the descriptor shows up
	a_lits_ready: assert property (@(posedge clk) disable iff (!rstN)
		desc_valid && lit_cnt != '0 |-> !empty)
		else $error("descriptor with %0d literals but FIFO empty", lit_cnt);

endmodule

// File: design/lz4_sequence_encoder.sv
`timescale 1ns/1ps

module lz4_sequence_encoder (
	input  logic          clk,
	input  logic          rstN,
	input  logic          lit_valid,
	input  logic [7:0]    lit_byte,
	input  logic          seq_valid,
	input  lz4_pkg::len_t lit_len,
	input  lz4_pkg::len_t match_len,
	input  lz4_pkg::ofs_t match_offset,
	input  logic          last,
	output logic          out_valid,
	output logic [7:0]    out_byte,
	output logic          seq_done,
	output logic          busy
);
	import lz4_pkg::*;

	// descriptor from length coder
	logic       desc_valid;
	nibble_t    lit_nib;
	nibble_t    mat_nib;
	len_t       lit_ext_cnt;
	logic [7:0] lit_ext_last;
	len_t       mat_ext_cnt;
	logic [7:0] mat_ext_last;
	len_t       lit_cnt;
	ofs_t       ofs;
	logic       is_last;

	// literal FIFO read side
	logic       rd_en;
	logic [7:0] rd_data;
	logic       empty;

	logic       emit_busy;

	lz4_length_coder u_length_coder (
		.clk          (clk),
		.rstN         (rstN),
		.seq_valid    (seq_valid),
		.lit_len      (lit_len),
		.match_len    (match_len),
		.match_offset (match_offset),
		.last         (last),
		.desc_valid   (desc_valid),
		.lit_nib      (lit_nib),
		.mat_nib      (mat_nib),
		.lit_ext_cnt  (lit_ext_cnt),
		.lit_ext_last (lit_ext_last),
		.mat_ext_cnt  (mat_ext_cnt),
		.mat_ext_last (mat_ext_last),
		.lit_cnt      (lit_cnt),
		.ofs          (ofs),
		.is_last      (is_last)
	);

	lz4_literal_fifo u_literal_fifo (
		.clk     (clk),
		.rstN    (rstN),
		.wr_en   (lit_valid),
		.wr_data (lit_byte),
		.rd_en   (rd_en),
		.rd_data (rd_data),
		.empty   (empty),
		.full    ()
	);

	lz4_sequence_emitter u_emitter (
		.clk          (clk),
		.rstN         (rstN),
		.desc_valid   (desc_valid),
		.lit_nib      (lit_nib),
		.mat_nib      (mat_nib),
		.lit_ext_cnt  (lit_ext_cnt),
		.lit_ext_last (lit_ext_last),
		.mat_ext_cnt  (mat_ext_cnt),
		.mat_ext_last (mat_ext_last),
		.lit_cnt      (lit_cnt),
		.ofs          (ofs),
		.is_last      (is_last),
		.rd_data      (rd_data),
		.empty        (empty),
		.rd_en        (rd_en),
		.out_valid    (out_valid),
		.out_byte     (out_byte),
		.seq_done     (seq_done),
		.busy         (emit_busy)
	);

	// cycle 0 is covered by the strobe itself, the emitter takes over from cycle 1
	assign busy = seq_valid || emit_busy;

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rstN
);

	// 4 ns period
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reset held over the first three rising edges
	initial
	begin
		rstN = 1'b0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

// File: verification/lz4_encoder_checker.sv
`timescale 1ns/1ps
`include "lz4_macros.svh"

module lz4_encoder_checker (
	input  logic          clk,
	input  logic          rstN,
	input  logic          lit_valid,
	input  logic [7:0]    lit_byte,
	input  logic          seq_valid,
	input  lz4_pkg::len_t lit_len,
	input  lz4_pkg::len_t match_len,
	input  lz4_pkg::ofs_t match_offset,
	input  logic          last,
	input  logic          out_valid,
	input  logic [7:0]    out_byte,
	input  logic          seq_done,
	input  logic          busy,
	output int            seq_count,
	output int            seq_fail_count,
	output int            error_count
);
	import lz4_pkg::*;

	logic [7:0] lit_q [$];
	logic [7:0] exp_q [$];
	logic       active;
	int         cyc;
	int         start_cyc;
	int         errors_at_start;
	len_t       cur_lit_len;
	len_t       cur_match_len;
	ofs_t       cur_offset;
	logic       cur_last;

	initial
	begin
		seq_count      = 0;
		seq_fail_count = 0;
		error_count    = 0;
		active         = 1'b0;
		cyc            = 0;
	end

	task automatic flag_error(input string msg);
		$display("%s", msg);
		error_count++;
	endtask

	// run of 255 bytes, then the remainder
	task automatic push_ext(input int corr);
		repeat (corr / `LZ4_EXT_BYTE)
			exp_q.push_back(8'hff);
		exp_q.push_back(8'(corr % `LZ4_EXT_BYTE));
	endtask

	////////////////////////////////////////////////////////////
	// expected stream for one sequence
	////////////////////////////////////////////////////////////

	task automatic start_sequence();
		int         lits;
		int         mlen;
		int         i;
		logic [3:0] lit_nib;
		logic [3:0] mat_nib;
		lits = int'(lit_len);
		mlen = int'(match_len);
		lit_nib = (lits >= `LZ4_LIT_NIB_MAX) ? 4'd15 : 4'(lits);
		if (last)
			mat_nib = 4'd0;
		else if (mlen - `LZ4_MIN_MATCH >= `LZ4_LIT_NIB_MAX)
			mat_nib = 4'd15;
		else
			mat_nib = 4'(mlen - `LZ4_MIN_MATCH);
		exp_q.delete();
		exp_q.push_back({lit_nib, mat_nib});
		if (lit_nib == 4'd15)
			push_ext(lits - `LZ4_LIT_NIB_MAX);
		for (i = 0; i < lits; i++)
		begin
			if (lit_q.size() == 0)
			begin
				flag_error($sformatf("sequence %0d wants %0d literals but only %0d were written",
					seq_count, lits, i));
				break;
			end
			exp_q.push_back(lit_q.pop_front());
		end
		// offset little endian, then the match extension
		if (!last)
		begin
			exp_q.push_back(match_offset[7:0]);
			exp_q.push_back(match_offset[15:8]);
			if (mat_nib == 4'd15)
				push_ext(mlen - `LZ4_LIT_NIB_MAX - `LZ4_MIN_MATCH);
		end
		cur_lit_len     = lit_len;
		cur_match_len   = match_len;
		cur_offset      = match_offset;
		cur_last        = last;
		start_cyc       = cyc;
		errors_at_start = error_count;
		active          = 1'b1;
	endtask

	task automatic finish_sequence();
		int errs;
		errs = error_count - errors_at_start;
		$display("seq %0d: lit_len %0d match_len %0d offset %04h last %0d, %0d bytes, %s",
			seq_count, cur_lit_len, cur_match_len, cur_offset, cur_last, exp_q.size(),
			(errs == 0) ? "ok" : $sformatf("%0d errors", errs));
		if (errs != 0)
			seq_fail_count++;
		seq_count++;
		active = 1'b0;
	endtask

	// token two cycles after the strobe, bytes back to back, then seq_done
	task automatic check_in_flight();
		int rel;
		int n;
		rel = cyc - start_cyc;
		n   = exp_q.size();
		if (busy !== 1'b1)
			flag_error($sformatf("CHECK FAILED busy seq %0d cycle %0d: expected 1 actual %h",
				seq_count, rel, busy));
		if (rel < n + 2 && seq_done)
			flag_error($sformatf("seq_done arrived early in sequence %0d", seq_count));
		if (rel < 2)
		begin
			if (out_valid)
				flag_error($sformatf("output byte ahead of the token in sequence %0d", seq_count));
		end
		else if (rel < n + 2)
		begin
			if (out_valid !== 1'b1)
				flag_error($sformatf("byte %0d of sequence %0d is missing", rel - 2, seq_count));
			else if (out_byte !== exp_q[rel - 2])
				flag_error($sformatf("CHECK FAILED out_byte seq %0d byte %0d: expected %02h actual %02h",
					seq_count, rel - 2, exp_q[rel - 2], out_byte));
		end
		else
		begin
			if (out_valid)
				flag_error($sformatf("extra byte %02h after sequence %0d", out_byte, seq_count));
			if (seq_done !== 1'b1)
				flag_error($sformatf("seq_done missing after sequence %0d", seq_count));
			finish_sequence();
		end
	endtask

	task automatic check_idle();
		if (out_valid)
			flag_error($sformatf("byte %02h came out with no sequence in flight", out_byte));
		if (seq_done)
			flag_error("seq_done pulsed with no sequence in flight");
		if (busy !== 1'b0)
			flag_error($sformatf("CHECK FAILED busy while idle: expected 0 actual %h", busy));
	endtask

	always @(posedge clk)
	begin
		if (rstN)
		begin
			cyc = cyc + 1;
			if (lit_valid)
				lit_q.push_back(lit_byte);
			if (seq_valid)
			begin
				if (active)
					flag_error($sformatf("new sequence while sequence %0d still in flight", seq_count));
				start_sequence();
			end
			if (active)
				check_in_flight();
			else
				check_idle();
		end
	end

endmodule

// File: verification/lz4_encoder_tb.sv
`timescale 1ns/1ps
`include "lz4_macros.svh"

module lz4_encoder_tb;
	import lz4_pkg::*;

	typedef struct packed {
		len_t lit_len;
		len_t match_len;
		ofs_t offset;
		logic last;
	} row_t;

	localparam int NUM_ROWS = 14;
	localparam int MARGIN   = 50;

	logic       clk;
	logic       rstN;
	logic       lit_valid;
	logic [7:0] lit_byte;
	logic       seq_valid;
	len_t       lit_len;
	len_t       match_len;
	ofs_t       match_offset;
	logic       last;
	logic       out_valid;
	logic [7:0] out_byte;
	logic       seq_done;
	logic       busy;

	int     seq_count;
	int     seq_fail_count;
	int     error_count;
	row_t   rows [NUM_ROWS];
	integer seed;
	int     cycle_cnt = 0;
	int     cycle_limit;

	tb_clock_gen u_clock_gen (
		.clk  (clk),
		.rstN (rstN)
	);

	lz4_sequence_encoder u_dut (
		.clk          (clk),
		.rstN         (rstN),
		.lit_valid    (lit_valid),
		.lit_byte     (lit_byte),
		.seq_valid    (seq_valid),
		.lit_len      (lit_len),
		.match_len    (match_len),
		.match_offset (match_offset),
		.last         (last),
		.out_valid    (out_valid),
		.out_byte     (out_byte),
		.seq_done     (seq_done),
		.busy         (busy)
	);

	lz4_encoder_checker u_checker (
		.clk            (clk),
		.rstN           (rstN),
		.lit_valid      (lit_valid),
		.lit_byte       (lit_byte),
		.seq_valid      (seq_valid),
		.lit_len        (lit_len),
		.match_len      (match_len),
		.match_offset   (match_offset),
		.last           (last),
		.out_valid      (out_valid),
		.out_byte       (out_byte),
		.seq_done       (seq_done),
		.busy           (busy),
		.seq_count      (seq_count),
		.seq_fail_count (seq_fail_count),
		.error_count    (error_count)
	);

	////////////////////////////////////////////////////////////
	// stimulus table: literals, match, offset, last
	////////////////////////////////////////////////////////////

	task automatic fill_table();
		// short sequences, single token byte
		rows[0]  = {16'd1,   16'd4,   16'h0001, 1'b0};
		rows[1]  = {16'd5,   16'd9,   16'h1234, 1'b0};
		rows[2]  = {16'd14,  16'd18,  16'hbeef, 1'b0};
		rows[3]  = {16'd7,   16'd12,  16'h00ff, 1'b0};
		// literal extension edges
		rows[4]  = {16'd15,  16'd4,   16'h0400, 1'b0};
		rows[5]  = {16'd269, 16'd6,   16'h2001, 1'b0};
		rows[6]  = {16'd270, 16'd8,   16'h7ffe, 1'b0};
		// match extension edges
		rows[7]  = {16'd3,   16'd19,  16'h0010, 1'b0};
		rows[8]  = {16'd2,   16'd273, 16'h0a0b, 1'b0};
		rows[9]  = {16'd6,   16'd600, 16'hfedc, 1'b0};
		// no literals, offset right after the token
		rows[10] = {16'd0,   16'd5,   16'h0302, 1'b0};
		rows[11] = {16'd0,   16'd40,  16'h0100, 1'b0};
		// closing sequences, literals only
		rows[12] = {16'd20,  16'd0,   16'h0000, 1'b1};
		rows[13] = {16'd9,   16'd0,   16'h0000, 1'b1};
	endtask

	function automatic int ext_bytes(input int len, input int bias);
		if (len < bias)
			ext_bytes = 0;
		else
			ext_bytes = (len - bias) / `LZ4_EXT_BYTE + 1;
	endfunction

	function automatic int row_cycles(input row_t r);
		int bytes;
		bytes = 1 + ext_bytes(r.lit_len, `LZ4_LIT_NIB_MAX) + r.lit_len;
		if (!r.last)
			bytes = bytes + 2 + ext_bytes(r.match_len, `LZ4_LIT_NIB_MAX + `LZ4_MIN_MATCH);
		// literal writes, strobe, descriptor, seq_done and one idle edge
		return bytes + r.lit_len + 4;
	endfunction

	task automatic run_row(input row_t r);
		int i;
		for (i = 0; i < r.lit_len; i++)
		begin
			@(posedge clk);
			lit_valid <= 1'b1;
			lit_byte  <= 8'($random(seed));
		end
		@(posedge clk);
		lit_valid    <= 1'b0;
		seq_valid    <= 1'b1;
		lit_len      <= r.lit_len;
		match_len    <= r.match_len;
		match_offset <= r.offset;
		last         <= r.last;
		@(posedge clk);
		seq_valid <= 1'b0;
		while (!seq_done)
			@(posedge clk);
	endtask

	// watchdog
	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
		begin
			$display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial
	begin
		int r;
		lit_valid    = 1'b0;
		lit_byte     = 8'h00;
		seq_valid    = 1'b0;
		lit_len      = '0;
		match_len    = '0;
		match_offset = '0;
		last         = 1'b0;
		seed         = 32'h8bde_6948;
		fill_table();
		cycle_limit = 3 + MARGIN;
		for (r = 0; r < NUM_ROWS; r++)
			cycle_limit = cycle_limit + row_cycles(rows[r]);
		wait (rstN === 1'b1);
		for (r = 0; r < NUM_ROWS; r++)
			run_row(rows[r]);
		repeat (4) @(posedge clk);
		@(negedge clk);
		if (seq_count != NUM_ROWS)
			$display("only %0d of %0d sequences completed", seq_count, NUM_ROWS);
		$display("summary: %0d sequences, %0d passed, %0d failed, %0d errors",
			seq_count, seq_count - seq_fail_count, seq_fail_count, error_count);
		if (error_count == 0 && seq_count == NUM_ROWS)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: src.f
+incdir+include
design/lz4_pkg.sv
design/lz4_length_coder.sv
design/lz4_literal_fifo.sv
design/lz4_sequence_emitter.sv
design/lz4_sequence_encoder.sv
verification/tb_clock_gen.sv
verification/lz4_encoder_checker.sv
verification/lz4_encoder_tb.sv

// File: Bender.yml
package:
  name: lz4_sequence_encoder

sources:
  - include_dirs:
      - include
    files:
      - design/lz4_pkg.sv
      - design/lz4_length_coder.sv
      - design/lz4_literal_fifo.sv
      - design/lz4_sequence_emitter.sv
      - design/lz4_sequence_encoder.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_clock_gen.sv
      - verification/lz4_encoder_checker.sv
      - verification/lz4_encoder_tb.sv
